// ==== common/bus_pkg.sv ====
`default_nettype none
`include "cpu85_params.svh"

package bus_pkg;

	typedef logic [`CPU85_ADDR_W-1:0] addr_t;
	typedef logic [`CPU85_DATA_W-1:0] data_t;

	typedef enum logic [2:0] {
		TS_TR = 3'd0, // reset
		TS_T1 = 3'd1, // address out, ale high
		TS_T2 = 3'd2, // strobe low
		TS_TW = 3'd3, // wait for ready
		TS_T3 = 3'd4, // data capture
		TS_T4 = 3'd5, // opcode decode
		TS_TT = 3'd6 // halted
	} tstate_t;

	typedef enum logic [1:0] {
		MC_OF = 2'd0, // opcode fetch
		MC_MR = 2'd1, // memory read
		MC_MW = 2'd2, // memory write
		MC_BIH = 2'd3 // halt, bus idle
	} mcycle_t;

	// {io/m_, s1, s0}
	typedef enum logic [2:0] {
		ST_HALT = 3'b000,
		ST_MW = 3'b001,
		ST_MR = 3'b010,
		ST_OF = 3'b011
	} status_t;

endpackage

`default_nettype wire

// ==== common/cpu85_params.svh ====
`ifndef CPU85_PARAMS_SVH
`define CPU85_PARAMS_SVH

// ------------------------------------------------------------
// bus and register file geometry
// ------------------------------------------------------------

`define CPU85_ADDR_W 16 // external address bus
`define CPU85_DATA_W 8 // external data bus

// B C D E H L, the M slot, then A
`define CPU85_REG_CNT 8

// ------------------------------------------------------------
// reset behaviour
// ------------------------------------------------------------

`define CPU85_RESET_PC 16'h0000 // first opcode fetch address

`endif

// ==== common/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef enum logic [2:0] {
		R_B = 3'd0,
		R_C = 3'd1,
		R_D = 3'd2,
		R_E = 3'd3,
		R_H = 3'd4,
		R_L = 3'd5,
		R_M = 3'd6, // memory at hl, or an immediate byte
		R_A = 3'd7
	} reg_idx_t;

	// same encoding as the opcode's dst field
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd2,
		ALU_ANA = 3'd4,
		ALU_XRA = 3'd5,
		ALU_ORA = 3'd6,
		ALU_CMP = 3'd7
	} alu_op_t;

	typedef struct packed {
		logic s; // sign
		logic z; // zero
		logic c; // carry or borrow
	} flags_t;

	// ------------------------------------------------------------
	// opcode word, two ways of looking at the same 8 bits
	// ------------------------------------------------------------

	typedef struct packed {
		logic [1:0] grp;
		reg_idx_t dst; // also the alu operation
		reg_idx_t src;
	} mov_view_t;

	typedef struct packed {
		logic [1:0] grp;
		logic [2:0] cond; // {flag select, unused, sense}
		logic [2:0] low;
	} br_view_t;

	typedef union packed {
		mov_view_t mv;
		br_view_t br;
	} opcode_u;

endpackage

`default_nettype wire

// ==== control/cycle_sequencer.sv ====
`default_nettype none

module cycle_sequencer (
	input logic clk,
	input logic rst,
	input logic i_ready,
	input logic [2:0] i_cycle_count,
	input logic i_cycle_write,
	input logic i_is_halt,
	output bus_pkg::tstate_t o_tstate,
	output logic [2:0] o_cycle_idx,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output bus_pkg::status_t o_status
);

	bus_pkg::tstate_t tstate_nx;
	bus_pkg::mcycle_t kind;
	bus_pkg::mcycle_t kind_nx;
	logic [2:0] idx_nx;
	logic last_cycle;
	logic strobe_nx;

	function automatic bus_pkg::status_t status_of(input bus_pkg::mcycle_t k);
		case (k)
			bus_pkg::MC_OF: status_of = bus_pkg::ST_OF;
			bus_pkg::MC_MR: status_of = bus_pkg::ST_MR;
			bus_pkg::MC_MW: status_of = bus_pkg::ST_MW;
			default: status_of = bus_pkg::ST_HALT;
		endcase
	endfunction

	assign last_cycle = (o_cycle_idx + 3'd1) == i_cycle_count;

	// ------------------------------------------------------------
	// next t-state and next machine cycle
	// ------------------------------------------------------------

	always_comb begin
		tstate_nx = o_tstate;
		idx_nx = o_cycle_idx;
		kind_nx = kind;
		case (o_tstate)
			bus_pkg::TS_TR: begin
				tstate_nx = bus_pkg::TS_T1;
				idx_nx = 3'd0;
				kind_nx = bus_pkg::MC_OF;
			end
			bus_pkg::TS_T1: tstate_nx = bus_pkg::TS_T2;
			bus_pkg::TS_T2, bus_pkg::TS_TW: begin
				tstate_nx = i_ready ? bus_pkg::TS_T3 : bus_pkg::TS_TW; // hold while not ready
			end
			bus_pkg::TS_T3, bus_pkg::TS_T4: begin
				if (o_tstate == bus_pkg::TS_T3 && kind == bus_pkg::MC_OF) begin
					tstate_nx = bus_pkg::TS_T4; // only a fetch has t4
				end else if (o_tstate == bus_pkg::TS_T4 && i_is_halt) begin
					tstate_nx = bus_pkg::TS_TT;
					kind_nx = bus_pkg::MC_BIH;
				end else begin
					tstate_nx = bus_pkg::TS_T1;
					if (last_cycle) begin
						idx_nx = 3'd0; // next instruction
						kind_nx = bus_pkg::MC_OF;
					end else begin
						idx_nx = o_cycle_idx + 3'd1;
						kind_nx = i_cycle_write ? bus_pkg::MC_MW : bus_pkg::MC_MR;
					end
				end
			end
			bus_pkg::TS_TT: tstate_nx = bus_pkg::TS_TT; // left only by reset
			default: tstate_nx = bus_pkg::TS_TR;
		endcase
	end

	assign strobe_nx = tstate_nx == bus_pkg::TS_T2 || tstate_nx == bus_pkg::TS_TW ||
		tstate_nx == bus_pkg::TS_T3;

	// ------------------------------------------------------------
	// state and pin registers
	// ------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_tstate <= bus_pkg::TS_TR;
			o_cycle_idx <= 3'd0;
			kind <= bus_pkg::MC_BIH;
			o_ale <= 1'b0;
			o_rd_n <= 1'b1;
			o_wr_n <= 1'b1;
			o_status <= bus_pkg::ST_HALT;
		end else begin
			o_tstate <= tstate_nx;
			o_cycle_idx <= idx_nx;
			kind <= kind_nx;
			o_ale <= tstate_nx == bus_pkg::TS_T1; // address latch pulse
			o_rd_n <= !(strobe_nx && kind_nx != bus_pkg::MC_MW);
			o_wr_n <= !(strobe_nx && kind_nx == bus_pkg::MC_MW);
			o_status <= status_of(kind_nx); // 000 once halted
		end
	end

endmodule

`default_nettype wire

// ==== control/instr_decoder.sv ====
`default_nettype none

module instr_decoder (
	input isa_pkg::opcode_u i_opcode,
	input isa_pkg::flags_t i_flags,
	input logic [2:0] i_cycle_idx,
	output logic [2:0] o_cycle_count,
	output logic o_cycle_write,
	output logic o_is_halt,
	output logic o_addr_sel_hl,
	output logic o_addr_sel_pc,
	output isa_pkg::reg_idx_t o_dst,
	output isa_pkg::reg_idx_t o_src,
	output isa_pkg::alu_op_t o_alu_op,
	output logic o_alu_en,
	output logic o_reg_we,
	output logic o_flag_we,
	output logic o_pc_load
);

	logic [1:0] grp;
	logic mem_dst, mem_src;
	logic is_mov, is_mvi, is_alu, is_imm;
	logic is_jmp, is_jcc, cond_true;
	logic [2:0] next_idx;
	logic last;

	always_comb begin
		grp = i_opcode.mv.grp;
		mem_dst = i_opcode.mv.dst == isa_pkg::R_M;
		mem_src = i_opcode.mv.src == isa_pkg::R_M;
		o_is_halt = grp == 2'b01 && mem_dst && mem_src; // mov m,m slot
		is_mov = grp == 2'b01 && !o_is_halt;
		is_mvi = grp == 2'b00 && mem_src;
		is_alu = grp == 2'b10 || (grp == 2'b11 && mem_src); // 11 ooo 110 is immediate
		is_imm = is_mvi || (is_alu && grp == 2'b11);

		// jumps read through the branch view
		is_jmp = i_opcode.br.grp == 2'b11 && i_opcode.br.cond == 3'b000 &&
			i_opcode.br.low == 3'b011;
		is_jcc = i_opcode.br.grp == 2'b11 && !i_opcode.br.cond[2] &&
			i_opcode.br.low == 3'b010; // nz z nc c only
		cond_true = (i_opcode.br.cond[1] ? i_flags.c : i_flags.z) == i_opcode.br.cond[0];

		if (is_jmp || is_jcc || (is_mvi && mem_dst)) begin
			o_cycle_count = 3'd3;
		end else if ((is_mov && (mem_src || mem_dst)) || is_mvi || (is_alu && mem_src)) begin
			o_cycle_count = 3'd2;
		end else begin
			o_cycle_count = 3'd1;
		end
		next_idx = i_cycle_idx + 3'd1;
		last = next_idx == o_cycle_count;

		// write flag for the cycle after the current one
		o_cycle_write = (is_mov && mem_dst && next_idx == 3'd1) ||
			(is_mvi && mem_dst && next_idx == 3'd2);

		o_addr_sel_hl = (i_cycle_idx == 3'd1 && (is_mov || (is_alu && grp == 2'b10))) ||
			(i_cycle_idx == 3'd2 && is_mvi);
		o_addr_sel_pc = !o_addr_sel_hl &&
			(i_cycle_idx == 3'd0 || is_imm || is_jmp || is_jcc);

		o_dst = is_alu ? isa_pkg::R_A : i_opcode.mv.dst;
		o_src = i_opcode.mv.src;
		o_alu_op = isa_pkg::alu_op_t'(i_opcode.mv.dst);
		o_alu_en = is_alu;
		o_reg_we = last && (((is_mov || is_mvi) && !mem_dst) || is_alu);
		o_flag_we = last && is_alu;
		o_pc_load = last && (is_jmp || (is_jcc && cond_true));
	end

endmodule

`default_nettype wire

// ==== datapath/alu.sv ====
`default_nettype none
`include "cpu85_params.svh"

module alu (
	input isa_pkg::alu_op_t i_op,
	input bus_pkg::data_t i_a,
	input bus_pkg::data_t i_b,
	output bus_pkg::data_t o_res,
	output isa_pkg::flags_t o_flags
);

	logic [`CPU85_DATA_W:0] wide; // extra bit is carry out

	always_comb begin
		case (i_op)
			isa_pkg::ALU_ADD: wide = {1'b0, i_a} + {1'b0, i_b};
			isa_pkg::ALU_SUB, isa_pkg::ALU_CMP: begin
				wide = {1'b0, i_a} - {1'b0, i_b}; // top bit set on borrow
			end
			isa_pkg::ALU_ANA: wide = {1'b0, i_a & i_b};
			isa_pkg::ALU_XRA: wide = {1'b0, i_a ^ i_b};
			isa_pkg::ALU_ORA: wide = {1'b0, i_a | i_b};
			default: wide = {1'b0, i_a}; // adc/sbb slots pass a
		endcase

		// compare sets flags only
		o_res = (i_op == isa_pkg::ALU_CMP) ? i_a : wide[`CPU85_DATA_W-1:0];

		o_flags.s = wide[`CPU85_DATA_W-1];
		o_flags.z = wide[`CPU85_DATA_W-1:0] == '0;
		o_flags.c = wide[`CPU85_DATA_W]; // always 0 for logic ops
	end

endmodule

`default_nettype wire

// ==== datapath/reg_file.sv ====
`default_nettype none
`include "cpu85_params.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input bus_pkg::tstate_t i_tstate,
	input logic [2:0] i_cycle_idx,
	input bus_pkg::data_t i_din,
	input isa_pkg::reg_idx_t i_dst,
	input isa_pkg::reg_idx_t i_src,
	input logic i_reg_we,
	input logic i_flag_we,
	input logic i_pc_load,
	input logic i_alu_en,
	input logic i_addr_sel_hl,
	input logic i_addr_sel_pc,
	input bus_pkg::data_t i_alu_res,
	input isa_pkg::flags_t i_alu_flags,
	output isa_pkg::opcode_u o_opcode,
	output isa_pkg::flags_t o_flags,
	output bus_pkg::data_t o_acc,
	output bus_pkg::data_t o_operand,
	output bus_pkg::addr_t o_addr,
	output bus_pkg::data_t o_dout
);

	// slot M doubles as the low byte of the operand latch
	bus_pkg::data_t regs [`CPU85_REG_CNT];
	bus_pkg::data_t latch_hi;
	bus_pkg::addr_t pc;
	logic fetch_end, wr_slot, byte_in;

	assign fetch_end = i_tstate == bus_pkg::TS_T3 && i_cycle_idx == 3'd0;
	assign wr_slot = (i_tstate == bus_pkg::TS_T4 && i_cycle_idx == 3'd0) ||
		(i_tstate == bus_pkg::TS_T3 && i_cycle_idx != 3'd0); // t4, or t3 of later cycles
	assign byte_in = i_tstate == bus_pkg::TS_T3 && i_cycle_idx != 3'd0 && i_addr_sel_pc;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= `CPU85_RESET_PC;
			o_opcode <= '0; // nop
		end else begin
			if (fetch_end) begin
				o_opcode <= i_din;
			end
			if (wr_slot && i_pc_load) begin
				pc <= {i_din, regs[isa_pkg::R_M]}; // jump target, high byte on the bus
			end else if (i_tstate == bus_pkg::TS_T3 && i_addr_sel_pc) begin
				pc <= pc + 1'b1; // opcode or operand byte consumed
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_slot && i_reg_we) begin
			regs[i_dst] <= i_alu_en ? i_alu_res : o_operand;
		end
		if (wr_slot && i_flag_we) begin
			o_flags <= i_alu_flags;
		end
		if (byte_in) begin
			if (i_cycle_idx == 3'd1) begin
				regs[isa_pkg::R_M] <= i_din; // first operand byte
			end else begin
				latch_hi <= i_din;
			end
		end
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------

	assign o_acc = regs[isa_pkg::R_A];
	assign o_dout = regs[i_src]; // immediate byte for mvi m
	assign o_operand = (i_src == isa_pkg::R_M) ? i_din : regs[i_src];

	assign o_addr = i_addr_sel_pc ? pc :
		i_addr_sel_hl ? {regs[isa_pkg::R_H], regs[isa_pkg::R_L]} :
		{latch_hi, regs[isa_pkg::R_M]};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu85_tb \
	-f verilog.f -o cpu85_sim

./obj_dir/cpu85_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
grep -q "Testbench passed" sim.log

// ==== src/cpu85_top.sv ====
`default_nettype none

module cpu85_top (
	input logic clk,
	input logic rst,
	input logic i_ready,
	input bus_pkg::data_t i_din,
	output bus_pkg::addr_t o_addr,
	output bus_pkg::data_t o_dout,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_iom_n,
	output logic o_s1,
	output logic o_s0
);

	bus_pkg::tstate_t tstate;
	bus_pkg::status_t status;
	logic [2:0] cycle_idx, cycle_count;
	logic cycle_write, is_halt, addr_sel_hl, addr_sel_pc;
	logic alu_en, reg_we, flag_we, pc_load;
	isa_pkg::reg_idx_t dst, src;
	isa_pkg::alu_op_t alu_op;
	isa_pkg::opcode_u opcode;
	isa_pkg::flags_t flags, alu_flags;
	bus_pkg::data_t acc, operand, alu_res;

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------

	cycle_sequencer cycle_sequencer_i (
		.clk(clk), .rst(rst), .i_ready(i_ready),
		.i_cycle_count(cycle_count), .i_cycle_write(cycle_write), .i_is_halt(is_halt),
		.o_tstate(tstate), .o_cycle_idx(cycle_idx),
		.o_ale(o_ale), .o_rd_n(o_rd_n), .o_wr_n(o_wr_n), .o_status(status)
	);

	instr_decoder instr_decoder_i (
		.i_opcode(opcode), .i_flags(flags), .i_cycle_idx(cycle_idx),
		.o_cycle_count(cycle_count), .o_cycle_write(cycle_write), .o_is_halt(is_halt),
		.o_addr_sel_hl(addr_sel_hl), .o_addr_sel_pc(addr_sel_pc),
		.o_dst(dst), .o_src(src), .o_alu_op(alu_op), .o_alu_en(alu_en),
		.o_reg_we(reg_we), .o_flag_we(flag_we), .o_pc_load(pc_load)
	);

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	reg_file reg_file_i (
		.clk(clk), .rst(rst), .i_tstate(tstate), .i_cycle_idx(cycle_idx), .i_din(i_din),
		.i_dst(dst), .i_src(src), .i_reg_we(reg_we), .i_flag_we(flag_we),
		.i_pc_load(pc_load), .i_alu_en(alu_en),
		.i_addr_sel_hl(addr_sel_hl), .i_addr_sel_pc(addr_sel_pc),
		.i_alu_res(alu_res), .i_alu_flags(alu_flags),
		.o_opcode(opcode), .o_flags(flags), .o_acc(acc), .o_operand(operand),
		.o_addr(o_addr), .o_dout(o_dout)
	);

	alu alu_i (
		.i_op(alu_op), .i_a(acc), .i_b(operand), .o_res(alu_res), .o_flags(alu_flags)
	);

	assign o_iom_n = status[2]; // status pins
	assign o_s1 = status[1];
	assign o_s0 = status[0];

endmodule

`default_nettype wire

// ==== test/cpu85_props.sv ====
`default_nettype none

module cpu85_props (
	input logic clk,
	input logic rst,
	input bus_pkg::tstate_t o_tstate,
	input logic o_ale,
	input logic o_rd_n,
	input logic o_wr_n,
	input bus_pkg::status_t o_status
);

	// ------------------------------------------------------------
	// bus strobe rules
	// ------------------------------------------------------------

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst) o_rd_n || o_wr_n)
		else $error("read and write strobes low together");

	a_ale_t1: assert property (@(posedge clk) disable iff (rst)
		o_ale |-> (o_tstate == bus_pkg::TS_T1 && o_rd_n && o_wr_n))
		else $error("ale outside T1 or with a strobe low");

	a_halt_status: assert property (@(posedge clk) disable iff (rst)
		o_tstate == bus_pkg::TS_TT |-> o_status == bus_pkg::ST_HALT)
		else $error("status not 000 while halted");

endmodule

bind cycle_sequencer cpu85_props props_i (
	.clk(clk), .rst(rst), .o_tstate(o_tstate), .o_ale(o_ale),
	.o_rd_n(o_rd_n), .o_wr_n(o_wr_n), .o_status(o_status)
);

`default_nettype wire

// ==== test/cpu85_tb.sv ====
`default_nettype none
`include "cpu85_params.svh"

module cpu85_tb;

	localparam int NUM_TESTS = 6;
	localparam int LIMIT = NUM_TESTS * 60 * 4 * 4 * 100;

	logic clk, rst, ready;
	bus_pkg::data_t din, dout;
	bus_pkg::addr_t addr;
	logic ale, rd_n, wr_n, iom_n, s1, s0;
	bus_pkg::status_t status_now;

	bus_pkg::data_t mem [65536];
	bus_pkg::addr_t wr_addr_q[$];
	bus_pkg::data_t wr_data_q[$];
	bus_pkg::addr_t fetch_q[$];
	bus_pkg::status_t fetch_st_q[$];
	bus_pkg::addr_t load_ptr, last_addr;
	bus_pkg::data_t last_dout;
	bus_pkg::status_t last_st;
	integer seed = 43;
	int max_delay, wait_cnt, delay_used, low_cnt, errors;
	logic strobe, strobe_prev, last_was_wr;

	assign status_now = bus_pkg::status_t'({iom_n, s1, s0});

	cpu85_top cpu85_top_i (
		.clk(clk), .rst(rst), .i_ready(ready), .i_din(din), .o_addr(addr), .o_dout(dout),
		.o_ale(ale), .o_rd_n(rd_n), .o_wr_n(wr_n), .o_iom_n(iom_n), .o_s1(s1), .o_s0(s0)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		#(LIMIT);
		$display("watchdog expired, the core never finished its programs");
		$display("Testbench failed");
		$fatal(1);
	end

	// ------------------------------------------------------------
	// failure reporting and compare tasks
	// ------------------------------------------------------------

	task automatic report_failure(input string msg);
		errors = errors + 1;
		$display("%s (time %0t)", msg, $time);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_write(input bus_pkg::addr_t ga, input bus_pkg::data_t gd,
			input bus_pkg::addr_t ea, input bus_pkg::data_t ed);
		if (ga !== ea || gd !== ed)
			report_failure($sformatf("MISMATCH %0t: write %h=%h, expected %h=%h",
				$time, ga, gd, ea, ed));
	endtask

	task automatic check_fetch(input bus_pkg::addr_t got, input bus_pkg::addr_t exp);
		if (got !== exp)
			report_failure($sformatf("MISMATCH %0t: fetch at %h, expected %h", $time, got, exp));
	endtask

	task automatic check_status(input bus_pkg::status_t got, input bus_pkg::status_t exp);
		if (got !== exp)
			report_failure($sformatf("MISMATCH %0t: status %b, expected %b", $time, got, exp));
	endtask

	task automatic record_write(input bus_pkg::addr_t a, input bus_pkg::data_t d);
		bus_pkg::addr_t ea;
		bus_pkg::data_t ed;
		mem[a] = d;
		if (wr_addr_q.size() == 0)
			report_failure($sformatf("unexpected write of %h to %h", d, a));
		ea = wr_addr_q.pop_front();
		ed = wr_data_q.pop_front();
		check_write(a, d, ea, ed);
	endtask

	// ------------------------------------------------------------
	// memory model with random ready delays
	// ------------------------------------------------------------

	always @(posedge clk) begin
		strobe = !rd_n || !wr_n;
		din <= mem[addr];
		if (ale) begin
			fetch_q.push_back(addr); // every T1 is logged
			fetch_st_q.push_back(status_now);
		end
		if (strobe) begin
			low_cnt = low_cnt + 1;
			last_addr = addr;
			last_dout = dout;
			last_st = status_now;
			last_was_wr = !wr_n;
			if (wait_cnt > 1) begin
				wait_cnt = wait_cnt - 1;
				ready <= 1'b0;
			end else begin
				ready <= 1'b1;
			end
		end else begin
			if (strobe_prev) begin
				if (low_cnt != 2 + delay_used)
					report_failure("strobe length does not match the ready delay");
				if (last_was_wr) begin
					check_status(last_st, bus_pkg::ST_MW);
					record_write(last_addr, last_dout);
				end
			end
			low_cnt = 0;
			delay_used = (max_delay == 0) ? 0 : int'({$random(seed)} % (max_delay + 1));
			wait_cnt = delay_used;
			ready <= delay_used == 0;
		end
		strobe_prev = strobe;
	end

	// ------------------------------------------------------------
	// program helpers
	// ------------------------------------------------------------

	task automatic start_program(input bus_pkg::addr_t at);
		for (int i = 0; i < 65536; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8); // whole address in the fill
		wr_addr_q.delete();
		wr_data_q.delete();
		load_ptr = at;
	endtask

	task automatic put(input bus_pkg::data_t b);
		mem[load_ptr] = b;
		load_ptr = load_ptr + 16'd1;
	endtask

	task automatic put_imm(input bus_pkg::data_t op, input bus_pkg::data_t b);
		put(op);
		put(b);
	endtask

	task automatic put_addr(input bus_pkg::data_t op, input bus_pkg::addr_t a);
		put(op);
		put(a[7:0]); // low byte first
		put(a[15:8]);
	endtask

	task automatic expect_write(input bus_pkg::addr_t a, input bus_pkg::data_t d);
		wr_addr_q.push_back(a);
		wr_data_q.push_back(d);
	endtask

	task automatic run_program();
		@(posedge clk);
		rst <= 1'b1;
		repeat (10) @(posedge clk);
		if (!rd_n || !wr_n || ale)
			report_failure("bus strobes active during reset");
		fetch_q.delete();
		fetch_st_q.delete();
		rst <= 1'b0;
		while (fetch_q.size() == 0) @(posedge clk);
		@(posedge clk);
		while (status_now != bus_pkg::ST_HALT) @(posedge clk);
		repeat (20) begin
			@(posedge clk);
			check_status(status_now, bus_pkg::ST_HALT);
			if (!rd_n || !wr_n)
				report_failure("bus strobe seen after halt");
		end
		if (wr_addr_q.size() != 0)
			report_failure("expected write never happened");
	endtask

	function automatic bus_pkg::data_t alu_expect(input isa_pkg::alu_op_t op,
			input bus_pkg::data_t a, input bus_pkg::data_t b);
		case (op)
			isa_pkg::ALU_ADD: alu_expect = a + b;
			isa_pkg::ALU_SUB: alu_expect = a - b;
			isa_pkg::ALU_ANA: alu_expect = a & b;
			isa_pkg::ALU_XRA: alu_expect = a ^ b;
			isa_pkg::ALU_ORA: alu_expect = a | b;
			default: alu_expect = a; // compare keeps A
		endcase
	endfunction

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------

	task automatic test_reset();
		start_program(16'h0000);
		put(8'h76); // hlt
		run_program();
		check_fetch(fetch_q[0], `CPU85_RESET_PC);
		check_status(fetch_st_q[0], bus_pkg::ST_OF);
	endtask

	task automatic test_moves();
		start_program(16'h0000);
		put_imm(8'h26, 8'h12); // mvi h
		put_imm(8'h2E, 8'h34); // mvi l
		put_imm(8'h3E, 8'hA5); // mvi a
		put(8'h77); // mov m,a
		put(8'h47); // mov b,a
		put_imm(8'h2E, 8'h35);
		put(8'h70); // mov m,b
		put_imm(8'h2E, 8'h36);
		put_imm(8'h36, 8'h3C); // mvi m
		put_imm(8'h3E, 8'h00);
		put_imm(8'h2E, 8'h34);
		put(8'h7E); // mov a,m reads back
		put_imm(8'h2E, 8'h37);
		put(8'h77);
		put(8'h76);
		expect_write(16'h1234, 8'hA5);
		expect_write(16'h1235, 8'hA5);
		expect_write(16'h1236, 8'h3C);
		expect_write(16'h1237, 8'hA5);
		run_program();
	endtask

	task automatic test_alu();
		isa_pkg::alu_op_t ops [6];
		bus_pkg::data_t a, b;
		ops = '{isa_pkg::ALU_ADD, isa_pkg::ALU_SUB, isa_pkg::ALU_ANA,
			isa_pkg::ALU_XRA, isa_pkg::ALU_ORA, isa_pkg::ALU_CMP};
		start_program(16'h0000);
		put_imm(8'h26, 8'h80);
		for (int k = 0; k < 12; k++) begin
			a = 8'($random(seed));
			b = 8'($random(seed));
			put_imm(8'h2E, 8'(k));
			put_imm(8'h3E, a);
			if (k < 6) begin
				put_imm(8'h06, b); // mvi b
				put({2'b10, ops[k % 6], 3'b000}); // register operand
			end else begin
				put_imm({2'b11, ops[k % 6], 3'b110}, b); // immediate operand
			end
			put(8'h77);
			expect_write({8'h80, 8'(k)}, alu_expect(ops[k % 6], a, b));
		end
		put(8'h76);
		run_program();
	endtask

	task automatic test_jumps();
		bus_pkg::data_t jcc [6] = '{8'hCA, 8'hCA, 8'hDA, 8'hDA, 8'hC2, 8'hD2};
		bus_pkg::data_t va [6] = '{8'h40, 8'h40, 8'h10, 8'h90, 8'h33, 8'h05};
		bus_pkg::data_t vb [6] = '{8'h40, 8'h41, 8'h20, 8'h20, 8'h30, 8'h06};
		logic use_sub [6] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
		bus_pkg::data_t r;
		bus_pkg::addr_t tgt;
		logic zf, cf, taken;
		start_program(16'h0000);
		put_addr(8'hC3, 16'h0040); // jmp 0040
		put(8'h76);
		load_ptr = 16'h0040;
		put_imm(8'h26, 8'h90);
		put_imm(8'h2E, 8'h00);
		put_imm(8'h3E, 8'h5A);
		put(8'h77);
		expect_write(16'h9000, 8'h5A);
		for (int k = 0; k < 6; k++) begin
			r = va[k] - vb[k];
			zf = r == 8'h00;
			cf = va[k] < vb[k];
			case (jcc[k])
				8'hCA: taken = zf;
				8'hC2: taken = !zf;
				8'hDA: taken = cf;
				default: taken = !cf;
			endcase
			put_imm(8'h2E, 8'(k + 1));
			put_imm(8'h3E, va[k]);
			put_imm(use_sub[k] ? 8'hD6 : 8'hFE, vb[k]); // sui or cpi
			tgt = load_ptr + 16'd5;
			put_addr(jcc[k], tgt);
			put_imm(8'h3E, 8'h11); // fall through marker
			put(8'h77);
			expect_write({8'h90, 8'(k + 1)}, taken ? (use_sub[k] ? r : va[k]) : 8'h11);
		end
		put(8'h76);
		run_program();
		check_status(fetch_st_q[1], bus_pkg::ST_MR); // jump operand read
		check_fetch(fetch_q[3], 16'h0040);
		check_status(fetch_st_q[3], bus_pkg::ST_OF);
	endtask

	initial begin
		rst = 1'b1;
		ready = 1'b1;
		din = '0;
		errors = 0;
		max_delay = 0;
		wait_cnt = 0;
		delay_used = 0;
		low_cnt = 0;
		strobe_prev = 1'b0;
		test_reset();
		test_moves();
		test_alu();
		max_delay = 3; // wait states from here on
		test_jumps();
		test_moves();
		test_alu();
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/bus_pkg.sv
common/isa_pkg.sv
control/cycle_sequencer.sv
control/instr_decoder.sv
datapath/reg_file.sv
datapath/alu.sv
src/cpu85_top.sv
test/cpu85_props.sv
test/cpu85_tb.sv
